/* cx4_dma.f */
+incdir+include
src/cx4_bus_pkg.sv
src/cx4_regs_pkg.sv
src/cx4_dma_if.sv
src/cx4_mmio_regs.sv
src/cx4_dma_fsm.sv
src/cx4_dma_counter.sv
src/cx4_datram.sv
src/cx4_dma.sv
sim/cx4_bus_model.sv
sim/cx4_dma_tb.sv

/* include/cx4_macros.svh */
`ifndef CX4_MACROS_SVH
`define CX4_MACROS_SVH

// data and address widths
`define CX4_DATA_W          8
`define CX4_HOST_ADDR_W     13
`define CX4_BUS_ADDR_W      24
`define CX4_MAPPED_ADDR_W   23
`define CX4_LEN_W           16
`define CX4_RAM_ADDR_W      12

// field view of the linear bus address
`define CX4_BANK_W          8
`define CX4_OFFSET_W        15

//////////////////////////////////////////////////
// host address map
//////////////////////////////////////////////////

`define CX4_RAM_HOST_LIMIT  13'h0c00  // data ram below this
`define CX4_MMIO_PAGE       8'hfa     // addr[12:5] of the 1f40 window
`define CX4_STATUS_FIRST    5'h13     // status mirrored up to 0x1f

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the cx4_dma testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns --top-module cx4_dma_tb \
  -f cx4_dma.f -o cx4_dma_sim
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/cx4_dma_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* sim/cx4_bus_model.sv */
`timescale 1ns/1ns
`default_nettype none

module cx4_bus_model (
  input  wire                                CLK,
  input  wire cx4_bus_pkg::cx4_mapped_addr_t bus_addr,
  input  wire                                bus_rrq,
  output logic                               bus_rdy,
  output cx4_bus_pkg::cx4_byte_t             bus_di
);
  import cx4_bus_pkg::*;

  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  logic [31:0]      lfsr_state = 32'h2c71bc86;
  cx4_mapped_addr_t req_addr;
  int unsigned      delay;

  // galois lfsr, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val        = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
    end
    return val;
  endfunction

  function automatic cx4_byte_t data_at(input cx4_mapped_addr_t a);
    return a[22:15] ^ {1'b0, a[14:8]} ^ a[7:0] ^ 8'h5a;
  endfunction

  initial begin
    bus_rdy = 1'b0;
    bus_di  = '0;
    forever begin
      @(negedge CLK);
      if (bus_rrq === 1'b1) begin
        req_addr = bus_addr;
        delay    = rand_bits(2) + 1;     // 1 to 4 cycles
        repeat (delay) @(negedge CLK);
        bus_rdy = 1'b1;
        bus_di  = data_at(req_addr);
        @(negedge CLK);
        bus_rdy = 1'b0;
        bus_di  = '0;
      end
    end
  end

endmodule

`default_nettype wire

/* sim/cx4_dma_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cx4_macros.svh"

module cx4_dma_tb;
  import cx4_bus_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 8;
  localparam int BYTE_CYCLES  = 7;    // request, 4 delay, write, advance
  localparam int XFER_BYTES   = 24;   // both transfers
  localparam int HOST_CYCLES  = 200;
  localparam int TIMEOUT_NS   =
    (RESET_CYCLES + XFER_BYTES * BYTE_CYCLES + HOST_CYCLES + 200) * CLK_PERIOD;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;
  localparam logic [`CX4_HOST_ADDR_W-1:0] STATUS_ADDR = {`CX4_MMIO_PAGE, `CX4_STATUS_FIRST};
  localparam cx4_byte_t ST_IDLE = 8'h02;
  localparam cx4_byte_t ST_BUSY = 8'h40;

  logic                        CLK = 1'b0;
  logic                        rst_n;
  logic                        cs;
  logic [`CX4_HOST_ADDR_W-1:0] addr;
  cx4_byte_t                   di;
  logic                        we;
  cx4_byte_t                   rd_data;
  cx4_mapped_addr_t            bus_addr;
  logic                        bus_rrq;
  logic                        bus_rdy;
  cx4_byte_t                   bus_di;
  logic [31:0]                 lfsr_state = 32'h2c71bc86;
  cx4_mapped_addr_t            req_log [$];

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  cx4_dma cx4_dma_inst (
    .CLK(CLK), .rst_n(rst_n), .cs(cs), .addr(addr), .di(di), .we(we), .rd_data(rd_data),
    .bus_addr(bus_addr), .bus_rrq(bus_rrq), .bus_rdy(bus_rdy), .bus_di(bus_di)
  );

  cx4_bus_model bus_model_inst (
    .CLK(CLK), .bus_addr(bus_addr), .bus_rrq(bus_rrq), .bus_rdy(bus_rdy), .bus_di(bus_di)
  );

  always @(negedge CLK) begin
    if (bus_rrq === 1'b1)
      req_log.push_back(bus_addr);   // one entry per request
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val        = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
    end
    return val;
  endfunction

  function automatic logic [`CX4_HOST_ADDR_W-1:0] reg_addr(input logic [4:0] offs);
    return {`CX4_MMIO_PAGE, offs};
  endfunction

  // a15 is not on the bus
  function automatic cx4_mapped_addr_t mapped_of(input logic [23:0] lin);
    return {lin[23:16], lin[14:0]};
  endfunction

  function automatic cx4_byte_t pattern_of(input cx4_mapped_addr_t a);
    return a[22:15] ^ {1'b0, a[14:8]} ^ a[7:0] ^ 8'h5a;
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_byte(input string name, input cx4_byte_t got, input cx4_byte_t exp);
    if (got !== exp)
      report_failure($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_addr(input string name, input cx4_mapped_addr_t got,
                            input cx4_mapped_addr_t exp);
    if (got !== exp)
      report_failure($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  // host accesses start and end on a falling edge
  task automatic host_write(input logic [`CX4_HOST_ADDR_W-1:0] a, input cx4_byte_t d);
    cs   = 1'b1;
    we   = 1'b1;
    addr = a;
    di   = d;
    @(negedge CLK);
    cs = 1'b0;
    we = 1'b0;
  endtask

  task automatic host_read(input logic [`CX4_HOST_ADDR_W-1:0] a, output cx4_byte_t d);
    cs   = 1'b1;
    we   = 1'b0;
    addr = a;
    @(negedge CLK);
    d  = rd_data;
    cs = 1'b0;
  endtask

  task automatic start_transfer(input logic [23:0] src, input logic [15:0] len,
                                input logic [23:0] tgt);
    req_log.delete();
    host_write(reg_addr(5'h00), src[7:0]);
    host_write(reg_addr(5'h01), src[15:8]);
    host_write(reg_addr(5'h02), src[23:16]);
    host_write(reg_addr(5'h03), len[7:0]);
    host_write(reg_addr(5'h04), len[15:8]);
    host_write(reg_addr(5'h05), tgt[7:0]);
    host_write(reg_addr(5'h06), tgt[15:8]);
    host_write(reg_addr(5'h07), tgt[23:16]);   // kicks the engine
  endtask

  // poll status until busy drops
  task automatic wait_done(input int nbytes);
    cx4_byte_t st;
    int        polls;
    polls = 0;
    @(negedge CLK);                    // start pulse cycle
    host_read(STATUS_ADDR, st);
    while (st != ST_IDLE) begin
      if (polls > nbytes * BYTE_CYCLES)
        report_failure($sformatf("transfer of %0d bytes never went idle", nbytes));
      check_byte("status", st, ST_BUSY);
      host_read(STATUS_ADDR, st);
      polls++;
    end
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic test_reset();
    cx4_byte_t d;
    if (bus_rrq !== 1'b0)
      report_failure("bus_rrq is not low after reset");
    host_read(STATUS_ADDR, d);
    check_byte("status", d, ST_IDLE);
    for (int i = 0; i < 8; i++) begin
      host_read(reg_addr(5'(i)), d);
      check_byte($sformatf("reg 0x%02h", i), d, 8'h00);
    end
  endtask

  task automatic test_registers();
    cx4_byte_t                   vals [0:6];
    cx4_byte_t                   d;
    logic [`CX4_HOST_ADDR_W-1:0] unmapped [0:3];
    unmapped = '{13'h0c00, 13'h0c01, 13'h1234, 13'h1f3f};
    for (int i = 0; i < 7; i++) begin       // 0x07 would start a transfer
      vals[i] = 8'(rand_bits(8));
      host_write(reg_addr(5'(i)), vals[i]);
    end
    for (int i = 0; i < 7; i++) begin
      host_read(reg_addr(5'(i)), d);
      check_byte($sformatf("reg 0x%02h", i), d, vals[i]);
    end
    host_write(reg_addr(5'h0a), 8'h3c);
    for (int i = 8; i < 19; i++) begin
      host_read(reg_addr(5'(i)), d);
      check_byte($sformatf("reg 0x%02h", i), d, 8'hff);
    end
    for (int i = 0; i < 4; i++) begin
      host_read(unmapped[i], d);
      check_byte($sformatf("host 0x%h", unmapped[i]), d, 8'h00);
    end
  endtask

  task automatic test_host_ram();
    logic [31:0] off;
    cx4_byte_t   wr;
    cx4_byte_t   d;
    for (int i = 0; i < 16; i++) begin
      off = rand_bits(12) % 32'hc00;
      wr  = 8'(rand_bits(8));
      host_write(13'(off), wr);
      host_read(13'(off), d);
      check_byte($sformatf("ram 0x%03h", off), d, wr);
    end
  endtask

  task automatic test_basic_transfer();
    logic [23:0] src;
    logic [11:0] tgt;
    cx4_byte_t   d;
    src = 24'(rand_bits(24));
    tgt = 12'h001 + 12'(rand_bits(11));     // keeps both guards below 0xc00
    host_write({1'b0, tgt - 12'd1}, 8'ha5);
    host_write({1'b0, tgt + 12'd20}, 8'hc3);
    start_transfer(src, 16'd20, {8'h5a, 4'h3, tgt});
    wait_done(20);
    host_read(STATUS_ADDR, d);
    check_byte("status", d, ST_IDLE);
    if (req_log.size() != 20)
      report_failure($sformatf("saw %0d bus requests instead of 20", req_log.size()));
    for (int i = 0; i < 20; i++) begin
      check_addr($sformatf("bus_addr[%0d]", i), req_log[i], mapped_of(src + 24'(i)));
      host_read({1'b0, tgt + 12'(i)}, d);
      check_byte($sformatf("ram 0x%03h", tgt + 12'(i)), d, pattern_of(mapped_of(src + 24'(i))));
    end
    host_read({1'b0, tgt - 12'd1}, d);
    check_byte("ram before target", d, 8'ha5);
    host_read({1'b0, tgt + 12'd20}, d);
    check_byte("ram after last byte", d, 8'hc3);
    host_read(reg_addr(5'h06), d);
    check_byte("reg 0x06", d, {4'h3, tgt[11:8]});
    host_read(reg_addr(5'h07), d);
    check_byte("reg 0x07", d, 8'h5a);
  endtask

  task automatic test_wrap_transfer();
    cx4_mapped_addr_t exp_addr [0:3];
    cx4_byte_t        d;
    exp_addr = '{23'h00fffe, 23'h00ffff, 23'h008000, 23'h008001};
    host_write(13'h002, 8'h99);
    start_transfer(24'h017ffe, 16'd4, 24'h000ffe);
    wait_done(4);
    if (req_log.size() != 4)
      report_failure($sformatf("saw %0d bus requests instead of 4", req_log.size()));
    for (int i = 0; i < 4; i++)
      check_addr($sformatf("bus_addr[%0d]", i), req_log[i], exp_addr[i]);
    host_read(13'h000, d);
    check_byte("ram 0x000", d, pattern_of(exp_addr[2]));
    host_read(13'h001, d);
    check_byte("ram 0x001", d, pattern_of(exp_addr[3]));
    host_read(13'h002, d);
    check_byte("ram 0x002", d, 8'h99);
  endtask

  initial begin
    rst_n = 1'b0;
    cs    = 1'b0;
    we    = 1'b0;
    addr  = '0;
    di    = '0;
    repeat (RESET_CYCLES) @(negedge CLK);
    rst_n = 1'b1;
    @(negedge CLK);
    test_reset();
    test_registers();
    test_host_ram();
    test_basic_transfer();
    test_wrap_transfer();
    $display("Simulation finished: PASS");
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("run did not complete within %0d ns", TIMEOUT_NS);
    $display("Simulation finished: FAIL");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

/* src/cx4_bus_pkg.sv */
`default_nettype none
`include "cx4_macros.svh"

package cx4_bus_pkg;

  typedef logic [`CX4_DATA_W-1:0]        cx4_byte_t;
  typedef logic [`CX4_MAPPED_ADDR_W-1:0] cx4_mapped_addr_t;

  typedef struct packed {
    logic [`CX4_BANK_W-1:0]   bank;
    logic                     a15;     // not driven onto the bus
    logic [`CX4_OFFSET_W-1:0] offset;
  } cx4_bus_addr_fields_s;

  // the engine counts through the linear view and drives the bus from the fields
  typedef union packed {
    logic [`CX4_BUS_ADDR_W-1:0] linear;
    cx4_bus_addr_fields_s       fields;
  } cx4_bus_addr_u;

endpackage

`default_nettype wire

/* src/cx4_datram.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cx4_macros.svh"

module cx4_datram (
  input  wire                         CLK,
  input  wire                         host_we,
  input  wire [`CX4_RAM_ADDR_W-1:0]   host_addr,
  input  wire cx4_bus_pkg::cx4_byte_t host_wdata,
  output cx4_bus_pkg::cx4_byte_t      host_rdata,
  input  wire                         dma_we,
  input  wire [`CX4_RAM_ADDR_W-1:0]   dma_addr,
  input  wire cx4_bus_pkg::cx4_byte_t dma_wdata
);
  import cx4_bus_pkg::*;

  cx4_byte_t mem [0:(1 << `CX4_RAM_ADDR_W)-1];   // 4k x 8

  always_ff @(posedge CLK) begin
    if (host_we)
      mem[host_addr] <= host_wdata;
    if (dma_we)
      mem[dma_addr] <= dma_wdata;      // dma wins on same address
    host_rdata <= mem[host_addr];      // old data on a write
  end

endmodule

`default_nettype wire

/* src/cx4_dma.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cx4_macros.svh"

module cx4_dma (
  input  wire                           CLK,
  input  wire                           rst_n,
  // host port
  input  wire                           cs,
  input  wire [`CX4_HOST_ADDR_W-1:0]    addr,
  input  wire cx4_bus_pkg::cx4_byte_t   di,
  input  wire                           we,
  output cx4_bus_pkg::cx4_byte_t        rd_data,
  // external bus
  output cx4_bus_pkg::cx4_mapped_addr_t bus_addr,
  output logic                          bus_rrq,
  input  wire                           bus_rdy,
  input  wire cx4_bus_pkg::cx4_byte_t   bus_di
);
  import cx4_bus_pkg::*;

  cx4_dma_if dma_bus ();

  logic                       host_ram_we;
  logic [`CX4_RAM_ADDR_W-1:0] host_ram_addr;
  cx4_byte_t                  host_ram_wdata;
  cx4_byte_t                  host_ram_rdata;
  logic                       load;
  logic                       advance;
  logic                       last;
  logic                       dma_ram_we;
  logic [`CX4_RAM_ADDR_W-1:0] dma_ram_addr;

  //////////////////////////////////////////////////
  // host registers and sequencer
  //////////////////////////////////////////////////

  cx4_mmio_regs regs_inst (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .cs        (cs),
    .addr      (addr),
    .di        (di),
    .we        (we),
    .rd_data   (rd_data),
    .ram_we    (host_ram_we),
    .ram_addr  (host_ram_addr),
    .ram_wdata (host_ram_wdata),
    .ram_rdata (host_ram_rdata),
    .dma       (dma_bus.regs)
  );

  cx4_dma_fsm fsm_inst (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .dma     (dma_bus.engine),
    .bus_rrq (bus_rrq),
    .bus_rdy (bus_rdy),
    .load    (load),
    .advance (advance),
    .last    (last),
    .ram_we  (dma_ram_we)
  );

  cx4_dma_counter counter_inst (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .dma      (dma_bus.engine),
    .load     (load),
    .advance  (advance),
    .last     (last),
    .bus_addr (bus_addr),
    .ram_addr (dma_ram_addr)
  );

  //////////////////////////////////////////////////
  // data ram
  //////////////////////////////////////////////////

  cx4_datram datram_inst (
    .CLK        (CLK),
    .host_we    (host_ram_we),
    .host_addr  (host_ram_addr),
    .host_wdata (host_ram_wdata),
    .host_rdata (host_ram_rdata),
    .dma_we     (dma_ram_we),
    .dma_addr   (dma_ram_addr),
    .dma_wdata  (bus_di)          // straight off the bus
  );

endmodule

`default_nettype wire

/* src/cx4_dma_counter.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cx4_macros.svh"

module cx4_dma_counter (
  input  wire                           CLK,
  input  wire                           rst_n,
  cx4_dma_if.engine                     dma,
  input  wire                           load,
  input  wire                           advance,
  output logic                          last,
  output cx4_bus_pkg::cx4_mapped_addr_t bus_addr,
  output logic [`CX4_RAM_ADDR_W-1:0]    ram_addr
);
  import cx4_bus_pkg::*;

  cx4_bus_addr_u              src_q;
  logic [`CX4_RAM_ADDR_W-1:0] tgt_q;
  logic [`CX4_LEN_W-1:0]      count_q;   // bytes still to move

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      src_q   <= '0;
      tgt_q   <= '0;
      count_q <= '0;
    end else if (load) begin
      src_q   <= dma.src;
      tgt_q   <= dma.tgt;
      count_q <= dma.len;
    end else if (advance) begin
      src_q.linear <= src_q.linear + 1'b1;  // carries through a15
      tgt_q        <= tgt_q + 1'b1;         // wraps at 4k
      count_q      <= count_q - 1'b1;       // len 0 wraps to ffff, 64k total
    end
  end

  assign last = (count_q == {{(`CX4_LEN_W-1){1'b0}}, 1'b1});

  // a15 dropped on the way out
  assign bus_addr = {src_q.fields.bank, src_q.fields.offset};
  assign ram_addr = tgt_q;

endmodule

`default_nettype wire

/* src/cx4_dma_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module cx4_dma_fsm (
  input  wire       CLK,
  input  wire       rst_n,
  cx4_dma_if.engine dma,
  output logic      bus_rrq,
  input  wire       bus_rdy,
  output logic      load,
  output logic      advance,
  input  wire       last,
  output logic      ram_we
);
  import cx4_regs_pkg::*;

  cx4_dma_state_e state_q;
  cx4_dma_state_e state_d;
  logic           rrq_q;
  logic           rrq_d;
  logic           got_byte;

  // rdy in the request cycle itself belongs to nobody
  assign got_byte = (state_q == WAIT) && !rrq_q && bus_rdy;

  //////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    rrq_d   = 1'b0;
    case (state_q)
      IDLE: begin
        if (dma.start)
          state_d = START;       // start while busy never gets here
      end
      START: begin
        state_d = WAIT;
        rrq_d   = 1'b1;
      end
      WAIT: begin
        if (got_byte)
          state_d = ADVANCE;     // no timeout
      end
      ADVANCE: begin
        if (last) begin
          state_d = IDLE;
        end else begin
          state_d = WAIT;
          rrq_d   = 1'b1;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      rrq_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      rrq_q   <= rrq_d;
    end
  end

  //////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////

  assign bus_rrq  = rrq_q;
  assign load     = (state_q == START);
  assign advance  = (state_q == ADVANCE);
  assign ram_we   = got_byte;    // bus_di only valid with rdy
  assign dma.busy = (state_q != IDLE);

endmodule

`default_nettype wire

/* src/cx4_dma_if.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cx4_macros.svh"

interface cx4_dma_if;
  import cx4_bus_pkg::*;

  cx4_bus_addr_u              src;
  logic [`CX4_LEN_W-1:0]      len;    // 0 means 65536
  logic [`CX4_RAM_ADDR_W-1:0] tgt;
  logic                       start;  // one cycle
  logic                       busy;

  // register block side
  modport regs (output src, len, tgt, start, input busy);

  // sequencer and counters; only the sequencer drives busy
  modport engine (input src, len, tgt, start, output busy);

endinterface

`default_nettype wire

/* src/cx4_mmio_regs.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cx4_macros.svh"

module cx4_mmio_regs (
  input  wire                         CLK,
  input  wire                         rst_n,
  input  wire                         cs,
  input  wire [`CX4_HOST_ADDR_W-1:0]  addr,
  input  wire cx4_bus_pkg::cx4_byte_t di,
  input  wire                         we,
  output cx4_bus_pkg::cx4_byte_t      rd_data,
  output logic                        ram_we,
  output logic [`CX4_RAM_ADDR_W-1:0]  ram_addr,
  output cx4_bus_pkg::cx4_byte_t      ram_wdata,
  input  wire cx4_bus_pkg::cx4_byte_t ram_rdata,
  cx4_dma_if.regs                     dma
);
  import cx4_regs_pkg::*;

  logic [`CX4_BUS_ADDR_W-1:0] src_q;
  logic [`CX4_LEN_W-1:0]      len_q;
  logic [`CX4_BUS_ADDR_W-1:0] tgt_q;     // only 11:0 reach the engine
  logic                       start_q;
  logic                       ram_sel_q;
  logic [`CX4_DATA_W-1:0]     reg_rd_q;
  logic                       ram_sel;
  logic                       mmio_sel;
  logic                       reg_wr;
  cx4_reg_offs_e              reg_offs;
  logic [`CX4_DATA_W-1:0]     reg_byte;
  logic [`CX4_DATA_W-1:0]     status;

  //////////////////////////////////////////////////
  // host decode
  //////////////////////////////////////////////////

  assign ram_sel  = cs && (addr < `CX4_RAM_HOST_LIMIT);
  assign mmio_sel = cs && (addr[`CX4_HOST_ADDR_W-1:5] == `CX4_MMIO_PAGE);
  assign reg_wr   = mmio_sel && we;
  assign reg_offs = cx4_reg_offs_e'(addr[4:0]);

  assign ram_we    = ram_sel && we;
  assign ram_addr  = addr[`CX4_RAM_ADDR_W-1:0];
  assign ram_wdata = di;

  //////////////////////////////////////////////////
  // dma registers
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      src_q   <= '0;
      len_q   <= '0;
      tgt_q   <= '0;
      start_q <= 1'b0;
    end else begin
      start_q <= 1'b0;
      if (reg_wr) begin
        case (reg_offs)
          DMASRC0: src_q[7:0]   <= di;
          DMASRC1: src_q[15:8]  <= di;
          DMASRC2: src_q[23:16] <= di;
          DMALEN0: len_q[7:0]   <= di;
          DMALEN1: len_q[15:8]  <= di;
          DMATGT0: tgt_q[7:0]   <= di;
          DMATGT1: tgt_q[15:8]  <= di;
          DMATGT2: begin
            tgt_q[23:16] <= di;
            start_q      <= 1'b1;  // kick
          end
          default: ;               // 0x08 and up ignore writes
        endcase
      end
    end
  end

  assign dma.src   = src_q;
  assign dma.len   = len_q;
  assign dma.tgt   = tgt_q[`CX4_RAM_ADDR_W-1:0];
  assign dma.start = start_q;

  //////////////////////////////////////////////////
  // read back
  //////////////////////////////////////////////////

  always_comb begin
    case (reg_offs)
      DMASRC0: reg_byte = src_q[7:0];
      DMASRC1: reg_byte = src_q[15:8];
      DMASRC2: reg_byte = src_q[23:16];
      DMALEN0: reg_byte = len_q[7:0];
      DMALEN1: reg_byte = len_q[15:8];
      DMATGT0: reg_byte = tgt_q[7:0];
      DMATGT1: reg_byte = tgt_q[15:8];
      DMATGT2: reg_byte = tgt_q[23:16];
      default: reg_byte = 8'hff;   // removed 1f48..1f52 block
    endcase
  end

  assign status = {1'b0, dma.busy, 4'b0000, ~dma.busy, 1'b0};

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      reg_rd_q  <= '0;
      ram_sel_q <= 1'b0;
    end else begin
      ram_sel_q <= ram_sel;
      if (!mmio_sel)
        reg_rd_q <= '0;            // ram hit or unmapped
      else if (addr[4:0] >= `CX4_STATUS_FIRST)
        reg_rd_q <= status;
      else
        reg_rd_q <= reg_byte;
    end
  end

  // ram output is already registered inside the ram
  assign rd_data = ram_sel_q ? ram_rdata : reg_rd_q;

endmodule

`default_nettype wire

/* src/cx4_regs_pkg.sv */
`default_nettype none

package cx4_regs_pkg;

  // byte offsets inside the register window
  typedef enum logic [4:0] {
    DMASRC0 = 5'h00,
    DMASRC1 = 5'h01,
    DMASRC2 = 5'h02,
    DMALEN0 = 5'h03,
    DMALEN1 = 5'h04,
    DMATGT0 = 5'h05,
    DMATGT1 = 5'h06,
    DMATGT2 = 5'h07   // write starts the transfer
  } cx4_reg_offs_e;

  //////////////////////////////////////////////////
  // dma sequencer states, one-hot
  //////////////////////////////////////////////////

  typedef enum logic [3:0] {
    IDLE    = 4'b0001,
    START   = 4'b0010,
    WAIT    = 4'b0100,
    ADVANCE = 4'b1000
  } cx4_dma_state_e;

endpackage

`default_nettype wire
